// ==== tests/lsu_stimulus.txt ====
# op(0 none 1 load 2 store) funct3 addr rs2 pc rd delay(ff random) byte_en rdata trap fault
# all columns hex
0 0 00001234 00000000 40000100 1f 00 0 00000000 0 0
2 2 00000010 8765f4a1 40000104 02 ff f 00000000 0 0
1 2 00000010 00000000 40000108 03 ff f 8765f4a1 0 0
2 0 00000011 123456c3 4000010c 04 ff 2 00000000 0 0
2 0 00000012 0000005e 40000110 05 ff 4 00000000 0 0
2 0 00000013 abcdef7f 40000114 06 ff 8 00000000 0 0
2 0 00000010 00000080 40000118 07 ff 1 00000000 0 0
2 1 00000014 55559abc 4000011c 08 ff 3 00000000 0 0
2 1 00000016 00001357 40000120 09 ff c 00000000 0 0
1 0 00000010 00000000 40000124 0a ff 1 ffffff80 0 0
1 4 00000010 00000000 40000128 0b ff 1 00000080 0 0
1 0 00000011 00000000 4000012c 0c ff 2 ffffffc3 0 0
1 4 00000011 00000000 40000130 0d ff 2 000000c3 0 0
1 0 00000012 00000000 40000134 0e ff 4 0000005e 0 0
1 4 00000013 00000000 40000138 0f ff 8 0000007f 0 0
1 0 00000013 00000000 4000013c 10 ff 8 0000007f 0 0
1 1 00000010 00000000 40000140 11 ff 3 ffffc380 0 0
1 5 00000010 00000000 40000144 12 ff 3 0000c380 0 0
1 1 00000011 00000000 40000148 13 ff 6 00005ec3 0 0
1 1 00000012 00000000 4000014c 14 ff c 00007f5e 0 0
1 5 00000012 00000000 40000150 15 ff c 00007f5e 0 0
1 1 00000014 00000000 40000154 16 ff 3 ffff9abc 0 0
1 5 00000014 00000000 40000158 17 ff 3 00009abc 0 0
1 1 00000016 00000000 4000015c 18 ff c 00001357 0 0
1 2 00000014 00000000 40000160 19 ff f 13579abc 0 0
1 1 00000013 00000000 40000164 1a 00 0 00000000 1 0
1 2 00000012 00000000 40000168 1b 00 0 00000000 1 0
2 2 00000011 ffffffff 4000016c 1c 00 0 00000000 1 0
2 1 00000017 0000ffff 40000170 1d 00 0 00000000 1 0
1 2 00000010 00000000 40000174 1e 3f f 00000000 0 1
0 0 00000abc 00000000 40000178 01 00 0 00000000 0 0
1 2 00000010 00000000 4000017c 02 ff f 7f5ec380 0 0

// ==== flist.f ====
source/lsu_pkg.sv
source/stage_reg.sv
source/mem_addr_gen.sv
source/load_align.sv
source/mem_ctrl_fsm.sv
source/req_timer.sv
source/lsu_top.sv
tests/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := lsu_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int TIMEOUT_CYCLES = 16;
    localparam int WAIT_LIMIT     = 200;

    typedef struct packed {
        logic [31:0] id;
        logic [31:0] pres;
        logic        fast;
        word_t       pc;
        word_t       alu_out;
        word_t       u_imm;
        logic        br_en;
        logic [4:0]  rd;
        word_t       rdata;
        logic        trap;
        logic        fault;
    } wb_exp_t;

    typedef struct packed {
        logic [31:0] id;
        word_t       addr;
        word_t       wdata;
        logic [3:0]  byte_en;
        logic        write;
        logic [7:0]  delay;
    } req_exp_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     exe_valid_i;
    exe_mem_t exe_data_i;
    logic     stall_o;
    mem_req_t dmem_req_o;
    word_t    dmem_rdata_i = '0;
    logic     dmem_resp_i = 1'b0;
    logic     wb_valid_o;
    mem_wb_t  wb_data_o;

    word_t    mem [64];
    wb_exp_t  wb_q [$];
    req_exp_t req_q [$];
    req_exp_t cur_req;
    logic     busy = 1'b0;
    int       wait_cnt = 0;
    int       cycle = 0;
    int       retire_at = 0;
    int       wb_val_errs = 0;
    int       wb_other_errs = 0;
    int       mem_val_errs = 0;
    int       mem_other_errs = 0;
    int       mon_errs = 0;
    int       main_errs = 0;

    lsu_top #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .exe_valid_i  (exe_valid_i),
        .exe_data_i   (exe_data_i),
        .stall_o      (stall_o),
        .dmem_req_o   (dmem_req_o),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_resp_i  (dmem_resp_i),
        .wb_valid_o   (wb_valid_o),
        .wb_data_o    (wb_data_o)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic int check_word(input int id, input string field,
                                      input word_t exp, input word_t act);
        check_word = 0;
        assert (exp === act) else begin
            $display("ERR instr %0d %s expected %h actual %h", id, field, exp, act);
            check_word = 1;
        end
    endfunction

    // writeback side where retires come in order and exactly once
    always @(negedge clk) begin
        wb_exp_t e;
        if (!rst && wb_valid_o) begin
            assert (wb_q.size() > 0) else begin
                $display("error: writeback pulse with no instruction outstanding");
                wb_other_errs++;
            end
            if (wb_q.size() > 0) begin
                e = wb_q.pop_front();
                wb_val_errs += check_word(e.id, "pc", e.pc, wb_data_o.pc);
                wb_val_errs += check_word(e.id, "alu_out", e.alu_out, wb_data_o.alu_out);
                wb_val_errs += check_word(e.id, "u_imm", e.u_imm, wb_data_o.u_imm);
                wb_val_errs += check_word(e.id, "br_en", {31'b0, e.br_en},
                                          {31'b0, wb_data_o.br_en});
                wb_val_errs += check_word(e.id, "rd", {27'b0, e.rd}, {27'b0, wb_data_o.rd});
                wb_val_errs += check_word(e.id, "rdata", e.rdata, wb_data_o.rdata);
                wb_val_errs += check_word(e.id, "trap", {31'b0, e.trap},
                                          {31'b0, wb_data_o.trap});
                wb_val_errs += check_word(e.id, "fault", {31'b0, e.fault},
                                          {31'b0, wb_data_o.fault});
                if (e.fast) begin
                    wb_val_errs += check_word(e.id, "latency", e.pres + 2, cycle);
                end else begin
                    wb_val_errs += check_word(e.id, "retire cycle", retire_at, cycle);
                end
            end
        end
    end

    // stall must stay high while a request waits for its response
    always @(negedge clk) begin
        #5;
        if (!rst && (dmem_req_o.read || dmem_req_o.write) && !dmem_resp_i) begin
            assert (stall_o) else begin
                $display("error: stall low while a memory request waits");
                mon_errs++;
            end
        end
    end

    // data memory with per-request response delay
    always @(negedge clk) begin
        logic [5:0] idx;
        dmem_resp_i  = 1'b0;
        dmem_rdata_i = 32'hdead_beef;
        if (rst) begin
            busy = 1'b0;
            for (int i = 0; i < 64; i++) begin
                mem[i] = (i * 32'h0403_0201) ^ 32'h5a3c_9600;
            end
        end else if (dmem_req_o.read || dmem_req_o.write) begin
            if (!busy) begin
                assert (req_q.size() > 0) else begin
                    $display("error: request from an instruction that must not reach memory");
                    mem_other_errs++;
                end
                if (req_q.size() > 0) begin
                    cur_req  = req_q[0];
                    busy     = 1'b1;
                    wait_cnt = 0;
                    // writeback follows the response edge or the timer drop
                    if (int'(cur_req.delay) < TIMEOUT_CYCLES) begin
                        retire_at = cycle + 1 + int'(cur_req.delay);
                    end else begin
                        retire_at = cycle + TIMEOUT_CYCLES;
                    end
                end
            end
            if (busy && wait_cnt == int'(cur_req.delay)) begin
                idx = dmem_req_o.addr[7:2];
                mem_val_errs += check_word(cur_req.id, "addr", cur_req.addr, dmem_req_o.addr);
                mem_val_errs += check_word(cur_req.id, "byte_en", {28'b0, cur_req.byte_en},
                                           {28'b0, dmem_req_o.byte_en});
                mem_val_errs += check_word(cur_req.id, "write", {31'b0, cur_req.write},
                                           {31'b0, dmem_req_o.write});
                mem_val_errs += check_word(cur_req.id, "read", {31'b0, !cur_req.write},
                                           {31'b0, dmem_req_o.read});
                dmem_rdata_i = mem[idx];
                if (dmem_req_o.write) begin
                    mem_val_errs += check_word(cur_req.id, "wdata", cur_req.wdata,
                                               dmem_req_o.wdata);
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_req_o.byte_en[b]) begin
                            mem[idx][8*b +: 8] = dmem_req_o.wdata[8*b +: 8];
                        end
                    end
                end
                dmem_resp_i = 1'b1;
                void'(req_q.pop_front());
                busy = 1'b0;
            end else if (busy) begin
                wait_cnt++;
            end
        end else if (busy) begin
            // request dropped by the timer
            void'(req_q.pop_front());
            busy = 1'b0;
        end
    end

    initial begin
        int          fd;
        int          n;
        int          id;
        int          gap;
        int          waited;
        int          total;
        int          pres;
        string       line;
        logic [31:0] op, f3, addr, wdata, pc, rd, dly, be, val, trap, fault;
        logic        hung;
        logic        accepted;
        wb_exp_t     e;
        req_exp_t    r;
        void'($urandom(32'h0692_f6d8));
        rst         = 1'b1;
        exe_valid_i = 1'b0;
        exe_data_i  = '0;
        hung        = 1'b0;
        id          = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (!stall_o && !wb_valid_o && !dmem_req_o.read && !dmem_req_o.write) else begin
            $display("error: outputs not idle after reset");
            main_errs++;
        end
        rst = 1'b0;
        fd = $fopen("tests/lsu_stimulus.txt", "r");
        assert (fd != 0) else begin
            $display("error: cannot open the stimulus file");
            main_errs++;
            hung = 1'b1;
        end
        while (!hung && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != 8'h23 &&
                $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        op, f3, addr, wdata, pc, rd, dly, be, val, trap, fault) == 11) begin
                gap = $urandom % 3;
                exe_valid_i = 1'b0;
                repeat (gap) @(negedge clk);
                exe_data_i.pc       = pc;
                exe_data_i.alu_out  = addr;
                exe_data_i.rs2_data = wdata;
                exe_data_i.u_imm    = pc ^ 32'h0001_2000;
                exe_data_i.br_en    = rd[0];
                exe_data_i.mem_op   = mem_op_e'(op[1:0]);
                exe_data_i.funct3   = f3[2:0];
                exe_data_i.rd       = rd[4:0];
                exe_valid_i         = 1'b1;
                id++;
                accepted = 1'b0;
                waited   = 0;
                while (!accepted && !hung) begin
                    #8;
                    accepted = !stall_o;
                    pres = cycle;
                    @(posedge clk);
                    #1;
                    if (accepted) begin
                        e.id      = id;
                        e.pres    = pres;
                        e.fast    = (op == 0) || trap[0];
                        e.pc      = pc;
                        e.alu_out = addr;
                        e.u_imm   = pc ^ 32'h0001_2000;
                        e.br_en   = rd[0];
                        e.rd      = rd[4:0];
                        e.rdata   = val;
                        e.trap    = trap[0];
                        e.fault   = fault[0];
                        wb_q.push_back(e);
                        if (op != 0 && !trap[0]) begin
                            r.id      = id;
                            r.addr    = {addr[31:2], 2'b00};
                            r.wdata   = wdata << (8 * addr[1:0]);
                            r.byte_en = be[3:0];
                            r.write   = (op == 2);
                            r.delay   = (dly[7:0] == 8'hff) ? 8'($urandom % 5) : dly[7:0];
                            req_q.push_back(r);
                        end
                    end else begin
                        waited++;
                        if (waited > WAIT_LIMIT) begin
                            $display("error: instruction %0d was never accepted", id);
                            main_errs++;
                            hung = 1'b1;
                        end
                    end
                    @(negedge clk);
                end
            end
        end
        exe_valid_i = 1'b0;
        waited = 0;
        while (!hung && (wb_q.size() > 0 || req_q.size() > 0)) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("error: instructions did not retire in time");
                main_errs++;
                hung = 1'b1;
            end
        end
        repeat (2) @(negedge clk);
        if (fd != 0) begin
            $fclose(fd);
        end
        total = wb_val_errs + mem_val_errs + wb_other_errs + mem_other_errs +
                mon_errs + main_errs;
        $display("errors: %0d value mismatches, %0d other failures",
                 wb_val_errs + mem_val_errs,
                 wb_other_errs + mem_other_errs + mon_errs + main_errs);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : lsu_tb

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              exe_valid_i,
    input  lsu_pkg::exe_mem_t exe_data_i,
    output logic              stall_o,
    output lsu_pkg::mem_req_t dmem_req_o,
    input  lsu_pkg::word_t    dmem_rdata_i,
    input  logic              dmem_resp_i,
    output logic              wb_valid_o,
    output lsu_pkg::mem_wb_t  wb_data_o
);
    import lsu_pkg::*;

    logic     exe_mem_ld;
    logic     mem_wb_ld;
    logic     retire;
    logic     req_en;
    logic     timer_run;
    logic     timeout;
    logic     fault;
    logic     misaligned;
    logic     ex_valid;
    exe_mem_t ex_q;
    mem_req_t addr_req;
    word_t    load_data;
    mem_wb_t  wb_next;

    stage_reg #(
        .payload_t (exe_mem_t)
    ) u_exe_mem (
        .clk     (clk),
        .rst     (rst),
        .load_i  (exe_mem_ld),
        .valid_i (exe_valid_i),
        .data_i  (exe_data_i),
        .valid_o (ex_valid),
        .data_o  (ex_q)
    );

    mem_addr_gen u_addr_gen (
        .ex_i         (ex_q),
        .req_o        (addr_req),
        .misaligned_o (misaligned)
    );

    load_align u_load_align (
        .rdata_i  (dmem_rdata_i),
        .offset_i (ex_q.alu_out[1:0]),
        .funct3_i (ex_q.funct3),
        .data_o   (load_data)
    );

    mem_ctrl_fsm u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .exe_valid_i   (exe_valid_i),
        .stage_valid_i (ex_valid),
        .mem_op_i      (ex_q.mem_op),
        .misaligned_i  (misaligned),
        .dmem_resp_i   (dmem_resp_i),
        .timeout_i     (timeout),
        .stall_o       (stall_o),
        .exe_mem_ld_o  (exe_mem_ld),
        .mem_wb_ld_o   (mem_wb_ld),
        .retire_o      (retire),
        .req_en_o      (req_en),
        .timer_run_o   (timer_run),
        .fault_o       (fault)
    );

    req_timer #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_timer (
        .clk       (clk),
        .rst       (rst),
        .run_i     (timer_run),
        .timeout_o (timeout)
    );

    // request bits only while the FSM has a request out
    always_comb begin
        dmem_req_o       = addr_req;
        dmem_req_o.read  = addr_req.read && req_en;
        dmem_req_o.write = addr_req.write && req_en;
    end

    always_comb begin
        wb_next.pc      = ex_q.pc;
        wb_next.alu_out = ex_q.alu_out;
        wb_next.u_imm   = ex_q.u_imm;
        wb_next.br_en   = ex_q.br_en;
        wb_next.rd      = ex_q.rd;
        // read data only counts in the response cycle of a load
        if ((ex_q.mem_op == MEM_LOAD) && req_en && dmem_resp_i) begin
            wb_next.rdata = load_data;
        end else begin
            wb_next.rdata = '0;
        end
        wb_next.trap  = misaligned;
        wb_next.fault = fault;
    end

    stage_reg #(
        .payload_t (mem_wb_t)
    ) u_mem_wb (
        .clk     (clk),
        .rst     (rst),
        .load_i  (mem_wb_ld),
        .valid_i (retire),
        .data_i  (wb_next),
        .valid_o (wb_valid_o),
        .data_o  (wb_data_o)
    );

endmodule : lsu_top

// ==== source/req_timer.sv ====
`timescale 1ns/1ps

module req_timer #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic run_i,
    output logic timeout_o
);
    localparam int CNT_W = $clog2(TIMEOUT_CYCLES);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(TIMEOUT_CYCLES - 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
        end else if (!run_i) begin
            count_q <= '0;
        end else if (count_q != LAST) begin
            count_q <= count_q + 1'b1;
        end
    end

    // saturates at the last count until run drops
    assign timeout_o = run_i && (count_q == LAST);

endmodule : req_timer

// ==== source/mem_ctrl_fsm.sv ====
`timescale 1ns/1ps

module mem_ctrl_fsm (
    input  logic             clk,
    input  logic             rst,
    input  logic             exe_valid_i,
    input  logic             stage_valid_i,
    input  lsu_pkg::mem_op_e mem_op_i,
    input  logic             misaligned_i,
    input  logic             dmem_resp_i,
    input  logic             timeout_i,
    output logic             stall_o,
    output logic             exe_mem_ld_o,
    output logic             mem_wb_ld_o,
    output logic             retire_o,
    output logic             req_en_o,
    output logic             timer_run_o,
    output logic             fault_o
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   pending;
    logic   retire_q;

    // stage holds a clean load or store that still needs memory
    assign pending = stage_valid_i && (mem_op_i != MEM_NONE) && !misaligned_i;

    always_comb begin
        state_d      = state_q;
        stall_o      = 1'b0;
        exe_mem_ld_o = 1'b0;
        retire_o     = 1'b0;
        req_en_o     = 1'b0;
        timer_run_o  = 1'b0;
        fault_o      = 1'b0;
        case (state_q)
            IDLE: begin
                // non-memory and trapped ops retire straight away
                stall_o      = pending;
                exe_mem_ld_o = !pending && (exe_valid_i || stage_valid_i);
                retire_o     = stage_valid_i && !pending;
                if (pending) begin
                    state_d = ACCESS;
                end
            end
            ACCESS: begin
                req_en_o    = 1'b1;
                timer_run_o = 1'b1;
                if (dmem_resp_i) begin
                    retire_o     = 1'b1;
                    exe_mem_ld_o = 1'b1;
                    state_d      = IDLE;
                end else if (timeout_i) begin
                    retire_o = 1'b1;
                    fault_o  = 1'b1;
                    stall_o  = 1'b1;
                    state_d  = DONE;
                end else begin
                    stall_o = 1'b1;
                end
            end
            DONE: begin
                // refill the stage one cycle after a dropped request
                exe_mem_ld_o = 1'b1;
                state_d      = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
        // extra load the cycle after retiring clears the writeback pulse
        mem_wb_ld_o = retire_o || retire_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= IDLE;
            retire_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            retire_q <= retire_o;
        end
    end

endmodule : mem_ctrl_fsm

// ==== source/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  lsu_pkg::word_t rdata_i,
    input  logic [1:0]     offset_i,
    input  logic [2:0]     funct3_i,
    output lsu_pkg::word_t data_o
);
    import lsu_pkg::*;

    word_t shifted;

    // addressed byte lands in bits 7:0
    assign shifted = rdata_i >> {offset_i, 3'b000};

    always_comb begin
        case (funct3_i)
            lb: begin
                data_o = {{24{shifted[7]}}, shifted[7:0]};
            end
            lbu: begin
                data_o = {24'h00_0000, shifted[7:0]};
            end
            lh: begin
                data_o = {{16{shifted[15]}}, shifted[15:0]};
            end
            lhu: begin
                data_o = {16'h0000, shifted[15:0]};
            end
            lw: begin
                data_o = rdata_i;
            end
            default: begin
                // illegal codes trap before reaching memory
                data_o = rdata_i;
            end
        endcase
    end

endmodule : load_align

// ==== source/mem_addr_gen.sv ====
`timescale 1ns/1ps

module mem_addr_gen (
    input  lsu_pkg::exe_mem_t ex_i,
    output lsu_pkg::mem_req_t req_o,
    output logic              misaligned_o
);
    import lsu_pkg::*;

    logic [1:0] offset;
    logic [3:0] mask;
    logic       bad;

    assign offset = ex_i.alu_out[1:0];

    always_comb begin
        mask = 4'b0000;
        bad  = 1'b0;
        case (ex_i.mem_op)
            MEM_LOAD: begin
                case (ex_i.funct3)
                    lb, lbu: mask = 4'b0001 << offset;
                    lh, lhu: begin
                        mask = 4'b0011 << offset;
                        bad  = (offset == 2'd3);
                    end
                    lw: begin
                        mask = 4'b1111;
                        bad  = (offset != 2'd0);
                    end
                    default: bad = 1'b1;
                endcase
            end
            MEM_STORE: begin
                case (ex_i.funct3)
                    sb: mask = 4'b0001 << offset;
                    sh: begin
                        mask = 4'b0011 << offset;
                        bad  = (offset == 2'd3);
                    end
                    sw: begin
                        mask = 4'b1111;
                        bad  = (offset != 2'd0);
                    end
                    default: bad = 1'b1;
                endcase
            end
            default: begin
                // non-memory ops keep the cleared mask
            end
        endcase
    end

    always_comb begin
        req_o.addr    = {ex_i.alu_out[31:2], 2'b00};
        // store bytes move up into their lanes
        req_o.wdata   = ex_i.rs2_data << {offset, 3'b000};
        req_o.byte_en = mask;
        req_o.read    = (ex_i.mem_op == MEM_LOAD);
        req_o.write   = (ex_i.mem_op == MEM_STORE);
    end

    assign misaligned_o = bad;

endmodule : mem_addr_gen

// ==== source/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = lsu_pkg::exe_mem_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);
    import lsu_pkg::*;

    logic     valid_q;
    payload_t data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q   <= 1'b0;
            data_q    <= '0;
            data_q.pc <= RESET_PC;
        end else if (load_i) begin
            // a bubble still loads, so valid drops after one cycle
            valid_q <= valid_i;
            data_q  <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule : stage_reg

// ==== source/lsu_pkg.sv ====
package lsu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;

    typedef logic [XLEN-1:0] word_t;

    // pc value held by an empty stage after reset
    localparam word_t RESET_PC = 32'h4000_0000;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10
    } mem_op_e;

    // load funct3
    localparam logic [FUNCT3_W-1:0] lb  = 3'b000;
    localparam logic [FUNCT3_W-1:0] lh  = 3'b001;
    localparam logic [FUNCT3_W-1:0] lw  = 3'b010;
    localparam logic [FUNCT3_W-1:0] lbu = 3'b100;
    localparam logic [FUNCT3_W-1:0] lhu = 3'b101;

    // store funct3
    localparam logic [FUNCT3_W-1:0] sb  = 3'b000;
    localparam logic [FUNCT3_W-1:0] sh  = 3'b001;
    localparam logic [FUNCT3_W-1:0] sw  = 3'b010;

    typedef struct packed {
        word_t                 pc;
        word_t                 alu_out;
        word_t                 rs2_data;
        word_t                 u_imm;
        logic                  br_en;
        mem_op_e               mem_op;
        logic [FUNCT3_W-1:0]   funct3;
        logic [REG_ADDR_W-1:0] rd;
    } exe_mem_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
        logic       read;
        logic       write;
    } mem_req_t;

    typedef struct packed {
        word_t                 pc;
        word_t                 alu_out;
        word_t                 u_imm;
        word_t                 rdata;
        logic                  br_en;
        logic [REG_ADDR_W-1:0] rd;
        // misaligned access or bad funct3
        logic                  trap;
        // no memory response in time
        logic                  fault;
    } mem_wb_t;

endpackage : lsu_pkg
